/* logic/uno_pkg.sv */
// ############################################################
// UNO deck engine shared types
// Card encoding, pile addressing, draw sizes, FSM states and
// the pile command bundle used between controller and piles
// ############################################################
package uno_pkg;

    // Card = {colour[1:0], value[3:0]}
    // Colour  0 red, 1 yellow, 2 green, 3 blue
    // Value   0..9 numbers, 10 skip, 11 reverse, 12 draw two,
    //         13 wild, 14 wild draw four
    typedef logic [5:0] card_t;

    typedef logic [6:0] pile_idx_t;  // One slot of a pile
    typedef logic [6:0] pile_cnt_t;  // Cards held, 0..108

    // One-hot, and the code equals the card count as well
    typedef enum logic [2:0] {
        DRAW_ONE  = 3'b001,
        DRAW_TWO  = 3'b010,
        DRAW_FOUR = 3'b100
    } draw_size_e;

    typedef enum logic [2:0] {
        ST_INIT,     // Ordered deck, waiting for start
        ST_SHUFFLE,  // Fisher-Yates pass over the draw pile
        ST_IDLE,     // Ready for draw requests and discards
        ST_DRAW,     // Emitting requested cards
        ST_REFILL    // Moving discards back into the draw pile
    } deck_state_e;

    localparam int DECK_SIZE       = 108;
    localparam int CARDS_PER_COLOR = 27;

    // Deck fill rule for slot k after reset
    //   colour is k / CARDS_PER_COLOR
    //   offset 0 within the colour holds value 0
    //   offsets 1..24 hold values 1..12, two of each
    //   offset 25 holds value 13, offset 26 holds value 14

    // Command from the controller to one pile, applied at the next edge
    typedef struct packed {
        logic      pop;    // Remove top card
        logic      push;   // Place card on top
        logic      swap;   // Exchange two slots
        pile_idx_t idx_a;  // Swap slot, read back on the draw pile
        pile_idx_t idx_b;  // Second swap slot
        card_t     card;   // Pushed card, or old idx_a entry on swap
    } pile_cmd_t;

endpackage

/* logic/shuffle_rng.sv */
// ############################################################
// Shuffle random source
// Free-running seed counter and 7-bit Fibonacci LFSR giving
// one pile index per cycle
// ############################################################
`timescale 1ns/1ps

module shuffle_rng import uno_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_seed,   // Reseed strobe from the start pulse
    output pile_idx_t o_rand
);

    logic [6:0] seed_cnt;  // Counts from reset so the start time picks the seed
    logic [6:0] lfsr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            seed_cnt <= '0;
            lfsr     <= 7'h01;
        end else begin
            seed_cnt <= seed_cnt + 1'b1;
            if (i_seed) begin
                lfsr <= {seed_cnt[6:1], 1'b1};  // Bit 0 set keeps it off zero
            end else begin
                lfsr <= {lfsr[3] ^ lfsr[0], lfsr[6:1]};  // x^7 + x^3 + 1
            end
        end
    end

    // LFSR runs over 1..127 and is shifted down so slot 0 can be picked
    assign o_rand = lfsr - 1'b1;

endmodule

/* logic/draw_pile.sv */
// ############################################################
// Draw pile
// Card stack that resets to the ordered deck and supports
// swap for shuffling, pop for drawing and push for refill
// ############################################################
`timescale 1ns/1ps

module draw_pile import uno_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  pile_cmd_t i_cmd,
    output card_t     o_top,    // Card at count-1
    output card_t     o_at_a,   // Card at i_cmd.idx_a
    output pile_cnt_t o_count
);

    card_t     pile [DECK_SIZE];
    pile_cnt_t count;

    // Reset-time card for slot k
    function automatic card_t fill_card(input int k);
        int         colour;
        int         offset;
        logic [3:0] value;
        colour = k / CARDS_PER_COLOR;
        offset = k % CARDS_PER_COLOR;
        if (offset == 0) begin
            value = 4'd0;
        end else if (offset <= 24) begin
            value = 4'((offset + 1) / 2);  // Pairs of 1..12
        end else begin
            value = 4'(offset - 12);       // 25 wild, 26 wild draw four
        end
        return {2'(colour), value};
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 0; k < DECK_SIZE; k++) begin
                pile[k] <= fill_card(k);
            end
            count <= pile_cnt_t'(DECK_SIZE);
        end else begin
            if (i_cmd.swap) begin
                // Old idx_a entry comes back on the command card
                pile[i_cmd.idx_a] <= pile[i_cmd.idx_b];
                pile[i_cmd.idx_b] <= i_cmd.card;
            end else if (i_cmd.push) begin
                pile[count] <= i_cmd.card;
                count       <= count + 1'b1;
            end else if (i_cmd.pop) begin
                count <= count - 1'b1;  // Top card simply left behind
            end
        end
    end

    // Empty pile shows a zero card
    assign o_top   = (count == '0) ? card_t'(0) : pile[count - 1'b1];
    assign o_at_a  = pile[i_cmd.idx_a];
    assign o_count = count;

    a_one_op: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({i_cmd.pop, i_cmd.push, i_cmd.swap}));

endmodule

/* logic/discard_pile.sv */
// ############################################################
// Discard pile
// Plain card stack, empty after reset, filled by played cards
// and emptied during refill
// ############################################################
`timescale 1ns/1ps

module discard_pile import uno_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  pile_cmd_t i_cmd,
    output card_t     o_top,
    output pile_cnt_t o_count
);

    card_t     pile [DECK_SIZE];  // Contents valid below count only
    pile_cnt_t count;

    always_ff @(posedge i_clk) begin
        if (i_cmd.push) begin
            pile[count] <= i_cmd.card;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (i_cmd.push) begin
            count <= count + 1'b1;
        end else if (i_cmd.pop) begin
            count <= count - 1'b1;
        end
    end

    assign o_top   = (count == '0) ? card_t'(0) : pile[count - 1'b1];
    assign o_count = count;

    // A full deck is the most that can ever be discarded
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd.push |-> count < pile_cnt_t'(DECK_SIZE));

endmodule

/* logic/deck_ctrl.sv */
// ############################################################
// Deck controller
// FSM for start shuffle, multi-card draw, discard intake and
// refill, plus the credit counter towards the card consumer
// ############################################################
`timescale 1ns/1ps

module deck_ctrl import uno_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_draw_req,
    input  draw_size_e i_draw_size,
    input  logic       i_discard_valid,
    input  card_t      i_discard_card,
    input  logic       i_credit_return,
    input  pile_idx_t  i_rand,
    input  card_t      i_draw_top,
    input  card_t      i_draw_at_a,
    input  pile_cnt_t  i_draw_count,
    input  card_t      i_discard_top,
    input  pile_cnt_t  i_discard_count,
    output pile_cmd_t  o_draw_cmd,
    output pile_cmd_t  o_discard_cmd,
    output logic       o_seed,
    output logic       o_card_valid,
    output card_t      o_card,
    output logic       o_ready
);

    localparam int CW = $clog2(CREDITS + 1);

    deck_state_e   state;
    deck_state_e   state_n;
    pile_idx_t     pos;       // Shuffle position, walks down to 0
    pile_idx_t     pos_n;
    logic [2:0]    remain;    // Cards still owed to the request
    logic [2:0]    remain_n;
    logic [CW-1:0] credits;   // Free slots in the consumer buffer

    always_comb begin
        state_n       = state;
        pos_n         = pos;
        remain_n      = remain;
        o_draw_cmd    = '0;
        o_discard_cmd = '0;
        o_seed        = 1'b0;
        o_card_valid  = 1'b0;
        case (state)
            ST_INIT: begin
                if (i_start) begin
                    o_seed  = 1'b1;  // New LFSR value next cycle
                    pos_n   = pile_idx_t'(i_draw_count - 1'b1);
                    state_n = ST_SHUFFLE;
                end
            end
            ST_SHUFFLE: begin
                if (pos == '0) begin
                    // Pass done, resume an interrupted draw if any
                    state_n = (remain != '0) ? ST_DRAW : ST_IDLE;
                end else if (i_rand <= pos) begin
                    o_draw_cmd.swap  = 1'b1;
                    o_draw_cmd.idx_a = pos;
                    o_draw_cmd.idx_b = i_rand;
                    o_draw_cmd.card  = i_draw_at_a;  // Entry at pos moves to i_rand
                    pos_n            = pos - 1'b1;
                end
                // Index above pos is rejected, try the next one
            end
            ST_IDLE: begin
                if (i_discard_valid) begin
                    o_discard_cmd.push = 1'b1;
                    o_discard_cmd.card = i_discard_card;
                end
                if (i_draw_req && (i_draw_size inside {DRAW_ONE, DRAW_TWO, DRAW_FOUR})) begin
                    remain_n = 3'(i_draw_size);  // One-hot code doubles as count
                    state_n  = ST_DRAW;
                end
            end
            ST_DRAW: begin
                if (i_draw_count == '0) begin
                    state_n = ST_REFILL;  // Out of cards mid-request
                end else if (credits != '0) begin
                    o_card_valid   = 1'b1;
                    o_draw_cmd.pop = 1'b1;
                    remain_n       = remain - 1'b1;
                    if (remain == 3'd1) begin
                        state_n = ST_IDLE;
                    end
                end
                // No credit, hold until the consumer returns one
            end
            ST_REFILL: begin
                if (i_discard_count != '0) begin
                    // One card per cycle, discard top onto draw pile
                    o_discard_cmd.pop = 1'b1;
                    o_draw_cmd.push   = 1'b1;
                    o_draw_cmd.card   = i_discard_top;
                end else if (i_draw_count == '0) begin
                    remain_n = '0;  // Both piles empty, rest of request dropped
                    state_n  = ST_IDLE;
                end else begin
                    pos_n   = pile_idx_t'(i_draw_count - 1'b1);
                    state_n = ST_SHUFFLE;
                end
            end
            default: state_n = ST_INIT;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= ST_INIT;
            pos    <= '0;
            remain <= '0;
        end else begin
            state  <= state_n;
            pos    <= pos_n;
            remain <= remain_n;
        end
    end

    // Spend one per emitted card, regain one per return pulse
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits <= CW'(CREDITS);
        end else begin
            credits <= credits - CW'(o_card_valid) + CW'(i_credit_return);
        end
    end

    assign o_card  = i_draw_top;  // Qualified by o_card_valid
    assign o_ready = (state == ST_IDLE);

    // Consumer must not return more than it was given
    a_credit_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        credits <= CW'(CREDITS));

    a_valid_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_card_valid |-> credits != '0);

    a_pop_draw: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_draw_cmd.pop |-> i_draw_count != '0);

    a_pop_discard: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_discard_cmd.pop |-> i_discard_count != '0);

endmodule

/* logic/uno_deck_top.sv */
// ############################################################
// UNO deck engine top level
// Joins the controller with the draw pile, discard pile and
// the shuffle random source
// ############################################################
`timescale 1ns/1ps

module uno_deck_top import uno_pkg::*; #(
    parameter int CREDITS = 4  // Consumer buffer depth
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_draw_req,
    input  draw_size_e i_draw_size,
    input  logic       i_discard_valid,
    input  card_t      i_discard_card,
    input  logic       i_credit_return,
    output logic       o_card_valid,
    output card_t      o_card,
    output logic       o_ready,
    output pile_cnt_t  o_cards_left
);

    pile_cmd_t draw_cmd;
    pile_cmd_t discard_cmd;
    card_t     draw_top;
    card_t     draw_at_a;
    card_t     discard_top;
    pile_cnt_t discard_count;
    pile_idx_t rand_idx;
    logic      seed;

    deck_ctrl #(
        .CREDITS (CREDITS)
    ) i_deck_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_draw_req      (i_draw_req),
        .i_draw_size     (i_draw_size),
        .i_discard_valid (i_discard_valid),
        .i_discard_card  (i_discard_card),
        .i_credit_return (i_credit_return),
        .i_rand          (rand_idx),
        .i_draw_top      (draw_top),
        .i_draw_at_a     (draw_at_a),
        .i_draw_count    (o_cards_left),  // Draw pile count is the status output
        .i_discard_top   (discard_top),
        .i_discard_count (discard_count),
        .o_draw_cmd      (draw_cmd),
        .o_discard_cmd   (discard_cmd),
        .o_seed          (seed),
        .o_card_valid    (o_card_valid),
        .o_card          (o_card),
        .o_ready         (o_ready)
    );

    draw_pile i_draw_pile (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (draw_cmd),
        .o_top   (draw_top),
        .o_at_a  (draw_at_a),
        .o_count (o_cards_left)
    );

    discard_pile i_discard_pile (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (discard_cmd),
        .o_top   (discard_top),
        .o_count (discard_count)
    );

    shuffle_rng i_shuffle_rng (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_seed  (seed),
        .o_rand  (rand_idx)
    );

endmodule

/* dv/tb_clk_gen.sv */
// ############################################################
// Testbench clock and reset
// Free-running clock, reset held low for the first cycles
// ############################################################
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;  // Released on an edge like the other inputs
    end

endmodule

/* dv/uno_deck_checks.sv */
// ############################################################
// Deck engine checker
// Credit and per-request assertions, plus a tally of every
// card seen on the output
// ############################################################
`timescale 1ns/1ps

module uno_deck_checks import uno_pkg::*; #(
    parameter int CREDITS = 4
) (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       i_card_valid,
    input card_t      i_card,
    input logic       i_ready,
    input pile_cnt_t  i_cards_left,
    input logic       i_draw_req,
    input draw_size_e i_draw_size,
    input logic       i_credit_return
);

    int        errors;
    int        hist [64];    // Cards seen per code since the last clear
    int        total;
    int        outstanding;  // Emitted, credit not yet back
    logic      req_active;   // Request taken, not yet closed
    int        want;         // Cards owed to that request
    int        seen;
    pile_cnt_t left0;        // Draw pile count at acceptance

    task automatic clear_tally();
        for (int c = 0; c < 64; c++) begin
            hist[c] = 0;
        end
        total = 0;
    endtask

    always @(posedge i_clk) begin
        if (i_rst_n && i_card_valid) begin
            hist[i_card] = hist[i_card] + 1;
            total        = total + 1;
        end
    end

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            outstanding <= 0;
            req_active  <= 1'b0;
            seen        <= 0;
        end else begin
            outstanding <= outstanding + int'(i_card_valid) - int'(i_credit_return);
            if (i_card_valid) begin
                seen <= seen + 1;
            end
            if (i_ready) begin
                req_active <= i_draw_req;  // Closes the old request, maybe opens one
                seen       <= 0;
                left0      <= i_cards_left;
                case (i_draw_size)
                    DRAW_ONE: want <= 1;
                    DRAW_TWO: want <= 2;
                    default:  want <= 4;
                endcase
            end
        end
    end

    a_valid_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_card_valid |-> outstanding < CREDITS)
    else begin
        errors++;
        $display("card emitted at %0t while all %0d credits were in use", $time, CREDITS);
    end

    // Ready back high closes the request
    a_req_count: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        req_active && i_ready |-> seen == want)
    else begin
        errors++;
        $display("mismatch at %0t: o_card_valid count expected %0d, got %0d",
                 $time, $sampled(want), $sampled(seen));
    end

    // Only when the pile could serve the request without a refill
    a_req_left: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        req_active && i_ready && int'(left0) >= want |->
        int'(i_cards_left) == int'(left0) - want)
    else begin
        errors++;
        $display("mismatch at %0t: o_cards_left expected %0d, got %0d", $time,
                 int'($sampled(left0)) - $sampled(want), $sampled(i_cards_left));
    end

endmodule

/* dv/uno_deck_tb.sv */
// ############################################################
// UNO deck engine testbench
// Start shuffle, full-deck drain with a credit stall, then
// refill from discards
// ############################################################
`timescale 1ns/1ps

module uno_deck_tb import uno_pkg::*; ();

    localparam int CREDITS = 4;

    logic       clk;
    logic       rst_n;
    logic       start         = 1'b0;
    logic       draw_req      = 1'b0;
    draw_size_e draw_size     = DRAW_ONE;
    logic       discard_valid = 1'b0;
    card_t      discard_card  = '0;
    logic       credit_return = 1'b0;
    logic       hold_returns  = 1'b0;  // Consumer keeps its credits
    logic       card_valid;
    card_t      card;
    logic       ready;
    pile_cnt_t  cards_left;
    int         seed      = 30;
    int         owed      = 0;         // Cards received, credit not yet sent
    int         gap       = 0;
    int         tb_errors = 0;
    int         timeouts  = 0;
    int         disc_hist [64];        // Discarded cards per code

    tb_clk_gen i_tb_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

    uno_deck_top #(.CREDITS(CREDITS)) i_uno_deck_top (
        .i_clk(clk), .i_rst_n(rst_n), .i_start(start),
        .i_draw_req(draw_req), .i_draw_size(draw_size),
        .i_discard_valid(discard_valid), .i_discard_card(discard_card),
        .i_credit_return(credit_return), .o_card_valid(card_valid),
        .o_card(card), .o_ready(ready), .o_cards_left(cards_left)
    );

    uno_deck_checks #(.CREDITS(CREDITS)) i_checks (
        .i_clk(clk), .i_rst_n(rst_n), .i_card_valid(card_valid), .i_card(card),
        .i_ready(ready), .i_cards_left(cards_left), .i_draw_req(draw_req),
        .i_draw_size(draw_size), .i_credit_return(credit_return)
    );

    // Consumer, one credit back per card after a random gap
    always @(posedge clk) begin
        credit_return <= 1'b0;
        if (card_valid) begin
            owed = owed + 1;
        end
        if (!hold_returns && owed > 0) begin
            if (gap == 0) begin
                credit_return <= 1'b1;
                owed = owed - 1;
                gap  = $random(seed) & 3;
            end else begin
                gap = gap - 1;
            end
        end
    end

    // Copies of each card in a fresh deck, straight from the fill rule
    function automatic int deck_count(input int code);
        int value;
        value = code % 16;
        if (value == 0 || value == 13 || value == 14) begin
            return 1;
        end
        return (value <= 12) ? 2 : 0;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
        else begin
            tb_errors++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ready && n < 20000);
        if (!ready) begin
            timeouts++;
            $display("timeout at %0t: o_ready stayed low during %s", $time, what);
        end
    endtask

    task automatic request(input int n);
        wait_ready("request");
        draw_req  <= 1'b1;
        draw_size <= (n == 1) ? DRAW_ONE : (n == 2) ? DRAW_TWO : DRAW_FOUR;
        @(posedge clk);
        draw_req  <= 1'b0;
    endtask

    task automatic discard(input card_t c);
        wait_ready("discard");
        discard_valid <= 1'b1;
        discard_card  <= c;
        @(posedge clk);
        discard_valid <= 1'b0;
    endtask

    initial begin
        int    n;
        int    left;
        card_t c;
        for (int k = 0; k < 20 && !rst_n; k++) begin
            @(posedge clk);
        end
        if (!rst_n) begin
            timeouts++;
            $display("timeout at %0t: reset was never released", $time);
        end
        @(posedge clk);
        check_value("o_ready", 0, ready);
        check_value("o_card_valid", 0, card_valid);
        check_value("o_cards_left", 108, cards_left);
        repeat ($random(seed) & 7) @(posedge clk);  // Start time picks the seed
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_ready("shuffle");
        check_value("o_cards_left", 108, cards_left);

        // Spend every credit, then a second request must stall
        i_checks.clear_tally();
        hold_returns <= 1'b1;
        request(CREDITS);
        wait_ready("first draw");
        request(4);
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            check_value("o_card_valid", 0, card_valid);
        end
        hold_returns <= 1'b0;
        wait_ready("stalled draw");

        // Drain the rest with random sizes that never overrun the pile
        left = 108 - CREDITS - 4;
        while (left > 0 && timeouts == 0) begin
            n = 1 << (($random(seed) & 3) % 3);
            while (n > left) begin
                n = n >> 1;
            end
            request(n);
            wait_ready("drain");
            left -= n;
        end
        check_value("cards drawn", 108, i_checks.total);
        for (int k = 0; k < 64; k++) begin
            check_value($sformatf("count of card %02h", k), deck_count(k), i_checks.hist[k]);
        end

        // Empty draw pile, so the next request runs a refill
        for (int k = 0; k < 6; k++) begin
            c = {2'($random(seed)), 4'($unsigned($random(seed)) % 15)};
            disc_hist[c]++;
            discard(c);
        end
        i_checks.clear_tally();
        request(4);
        wait_ready("refill draw");
        check_value("cards drawn", 4, i_checks.total);
        for (int k = 0; k < 64; k++) begin
            assert (i_checks.hist[k] <= disc_hist[k])
            else begin
                tb_errors++;
                $display("card %02h came back more often than it was discarded", k);
            end
        end
        check_value("o_cards_left", 2, cards_left);
        request(2);  // Last two, plain pops again
        wait_ready("final draw");

        repeat (4) @(posedge clk);
        $display("errors: checker %0d, testbench %0d, timeouts %0d",
                 i_checks.errors, tb_errors, timeouts);
        if (i_checks.errors + tb_errors + timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* build.f */
logic/uno_pkg.sv
logic/shuffle_rng.sv
logic/draw_pile.sv
logic/discard_pile.sv
logic/deck_ctrl.sv
logic/uno_deck_top.sv
dv/tb_clk_gen.sv
dv/uno_deck_checks.sv
dv/uno_deck_tb.sv
